// File: design/spmv_defines.svh
`ifndef SPMV_DEFINES_SVH
`define SPMV_DEFINES_SVH

// entries per batch and dense vector length, power of two
`define SPMV_N 8

// value width, all arithmetic wraps at this width
`define SPMV_W 8

// column index and segment id width, also the number of scan levels
`define SPMV_LG_N ($clog2(`SPMV_N))

// segment count width, holds 0 to SPMV_N
`define SPMV_CNT_W (`SPMV_LG_N + 1)

`endif

// File: design/spmv_pkg.sv
`default_nettype none

`include "spmv_defines.svh"

package spmv_pkg;

    typedef logic [`SPMV_W-1:0] value_t;

    // one sparse entry of the input batch
    typedef struct packed {
        value_t                 value;
        logic [`SPMV_LG_N-1:0]  col;
        logic                   split;
    } lhs_entry_t;

    typedef lhs_entry_t [`SPMV_N-1:0] lhs_batch_t;

    typedef value_t [`SPMV_N-1:0] rhs_vec_t;

    // one element in flight through the lane
    typedef struct packed {
        value_t                 sum;
        logic [`SPMV_LG_N-1:0]  seg_id;
        logic                   split;
    } lane_elem_t;

    typedef struct packed {
        logic                           valid;
        lane_elem_t [`SPMV_N-1:0]       elem;
    } lane_stage_t;

    // lane result, closed segment sums in segment order
    typedef struct packed {
        value_t [`SPMV_N-1:0]           slot;
        value_t                         halo;
        logic [`SPMV_CNT_W-1:0]         count;
    } seg_out_t;

endpackage

`default_nettype wire

// File: design/operand_gather.sv
`timescale 1ns/1ps
`default_nettype none

`include "spmv_defines.svh"

module operand_gather
    import spmv_pkg::*;
(
    input  wire logic       clock,
    input  wire logic       reset,
    input  wire logic       rhs_load,
    input  wire rhs_vec_t   rhs_data,
    input  wire logic       in_valid,
    input  wire lhs_batch_t in_batch,
    output lane_stage_t     gathered
);

    rhs_vec_t                   rhs_q;
    lane_elem_t [`SPMV_N-1:0]   elem_d;
    lane_elem_t [`SPMV_N-1:0]   elem_q;
    logic                       valid_q;

    // ------------------------------------------------------------
    // dense vector, kept until the next load
    // ------------------------------------------------------------
    // a batch sampled on the load edge still sees the old vector
    always_ff @(posedge clock) begin
        if (reset) begin
            rhs_q <= '0;
        end else if (rhs_load) begin
            rhs_q <= rhs_data;
        end
    end

    // ------------------------------------------------------------
    // crossbar, multipliers and segment numbering
    // ------------------------------------------------------------
    always_comb begin
        logic [`SPMV_LG_N-1:0] seg_run;

        seg_run = '0;
        for (int i = 0; i < `SPMV_N; i++) begin
            // product truncated to W bits
            elem_d[i].sum    = in_batch[i].value * rhs_q[in_batch[i].col];
            elem_d[i].seg_id = seg_run;
            elem_d[i].split  = in_batch[i].split;
            // a split closes the segment, the next entry opens a new one
            seg_run = seg_run + `SPMV_LG_N'(in_batch[i].split);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        elem_q <= elem_d;
    end

    assign gathered = '{valid: valid_q, elem: elem_q};

endmodule

`default_nettype wire

// File: design/segmented_scan.sv
`timescale 1ns/1ps
`default_nettype none

`include "spmv_defines.svh"

module segmented_scan
    import spmv_pkg::*;
(
    input  wire logic           clock,
    input  wire logic           reset,
    input  wire lane_stage_t    gathered,
    output lane_stage_t         scanned
);

    // stage[0] is the input, stage[k] the output of level k-1
    lane_stage_t stage [`SPMV_LG_N+1];

    assign stage[0] = gathered;

    // ------------------------------------------------------------
    // one registered level per stride 1, 2, 4 ...
    // ------------------------------------------------------------
    for (genvar lv = 0; lv < `SPMV_LG_N; lv++) begin : g_level
        localparam int STRIDE = 1 << lv;

        lane_elem_t [`SPMV_N-1:0]   elem_d;
        lane_elem_t [`SPMV_N-1:0]   elem_q;
        logic                       valid_q;

        // seg ids are non-decreasing, so equal ids at i and i-STRIDE
        // mean every element in between is in the same segment
        always_comb begin
            elem_d = stage[lv].elem;
            for (int i = STRIDE; i < `SPMV_N; i++) begin
                if (stage[lv].elem[i].seg_id == stage[lv].elem[i-STRIDE].seg_id) begin
                    elem_d[i].sum = stage[lv].elem[i].sum + stage[lv].elem[i-STRIDE].sum;
                end
            end
        end

        always_ff @(posedge clock) begin
            if (reset) begin
                valid_q <= 1'b0;
            end else begin
                valid_q <= stage[lv].valid;
            end
        end

        // seg ids and splits ride along unchanged
        always_ff @(posedge clock) begin
            elem_q <= elem_d;
        end

        assign stage[lv+1] = '{valid: valid_q, elem: elem_q};
    end

    // every element now holds the inclusive sum of its segment
    assign scanned = stage[`SPMV_LG_N];

endmodule

`default_nettype wire

// File: design/segment_collect.sv
`timescale 1ns/1ps
`default_nettype none

`include "spmv_defines.svh"

module segment_collect
    import spmv_pkg::*;
(
    input  wire logic           clock,
    input  wire logic           reset,
    input  wire lane_stage_t    scanned,
    output logic                out_valid,
    output seg_out_t            result
);

    value_t [`SPMV_N-1:0]       slot_d;
    value_t                     halo_d;
    logic [`SPMV_CNT_W-1:0]     count_d;
    lane_elem_t                 last;

    assign last = scanned.elem[`SPMV_N-1];

    // ------------------------------------------------------------
    // route segment-end sums into ordered slots
    // ------------------------------------------------------------
    always_comb begin
        slot_d = '0;
        for (int i = 0; i < `SPMV_N; i++) begin
            // at most one closing element per segment id
            if (scanned.elem[i].split) begin
                slot_d[scanned.elem[i].seg_id] = scanned.elem[i].sum;
            end
        end
    end

    // trailing open segment goes out as the halo
    always_comb begin
        if (last.split) begin
            halo_d = '0;
        end else begin
            halo_d = last.sum;
        end
    end

    // closed segments before the last element, plus the last one if it closes
    always_comb begin
        count_d = {1'b0, last.seg_id} + `SPMV_CNT_W'(last.split);
    end

    // ------------------------------------------------------------
    // output register
    // ------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= scanned.valid;
        end
    end

    always_ff @(posedge clock) begin
        result.slot  <= slot_d;
        result.halo  <= halo_d;
        result.count <= count_d;
    end

endmodule

`default_nettype wire

// File: design/spmv_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "spmv_defines.svh"

module spmv_lane
    import spmv_pkg::*;
(
    input  wire logic       clock,
    input  wire logic       reset,
    input  wire logic       rhs_load,
    input  wire rhs_vec_t   rhs_data,
    input  wire logic       in_valid,
    input  wire lhs_batch_t in_batch,
    output logic            out_valid,
    output seg_out_t        result
);

    // stage links, valid travels with the data
    lane_stage_t gathered;
    lane_stage_t scanned;

    // ------------------------------------------------------------
    // gather and multiply, 1 cycle
    // ------------------------------------------------------------
    operand_gather u_gather (
        .clock      (clock),
        .reset      (reset),
        .rhs_load   (rhs_load),
        .rhs_data   (rhs_data),
        .in_valid   (in_valid),
        .in_batch   (in_batch),
        .gathered   (gathered)
    );

    // ------------------------------------------------------------
    // segmented reduction, SPMV_LG_N cycles
    // ------------------------------------------------------------
    segmented_scan u_scan (
        .clock      (clock),
        .reset      (reset),
        .gathered   (gathered),
        .scanned    (scanned)
    );

    // ------------------------------------------------------------
    // slot packing, halo and count, 1 cycle
    // ------------------------------------------------------------
    segment_collect u_collect (
        .clock      (clock),
        .reset      (reset),
        .scanned    (scanned),
        .out_valid  (out_valid),
        .result     (result)
    );

endmodule

`default_nettype wire

// File: dv/spmv_model.svh
`ifndef SPMV_MODEL_SVH
`define SPMV_MODEL_SVH

// ------------------------------------------------------------
// reference model of one lane result
// ------------------------------------------------------------
// walks the entries in order and keeps a running sum of the
// open segment, closing it into the next slot at each split
function automatic seg_out_t expected_result(
    input lhs_batch_t batch,
    input rhs_vec_t   vec
);
    seg_out_t res;
    value_t   prod;
    value_t   acc;
    int       seg;

    res = '0;
    acc = '0;
    seg = 0;
    for (int i = 0; i < `SPMV_N; i++) begin
        // everything wraps at SPMV_W bits
        prod = batch[i].value * vec[batch[i].col];
        acc  = acc + prod;
        if (batch[i].split) begin
            res.slot[seg] = acc;
            seg++;
            acc = '0;
        end
    end
    // left at zero when the last entry closed its segment
    res.halo  = acc;
    res.count = seg[`SPMV_CNT_W-1:0];
    return res;
endfunction

// ------------------------------------------------------------
// random source
// ------------------------------------------------------------
// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;

    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
endfunction

`endif

// File: dv/spmv_lane_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "spmv_defines.svh"

module spmv_lane_tb
    import spmv_pkg::*;
();

    localparam int CLOCK_PERIOD   = 4;
    localparam int RESET_CYCLES   = 10;
    localparam int LATENCY        = `SPMV_LG_N + 2;
    localparam int QUIET_CYCLES   = 12;
    localparam int FIXED_BATCHES  = 6;
    localparam int RANDOM_BATCHES = 150;
    localparam int RELOAD_CYCLES  = 80;
    localparam int GAP_CYCLES     = 120;
    localparam int TAIL_CYCLES    = 10;
    localparam int MARGIN_CYCLES  = 50;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + QUIET_CYCLES + 1 + 2 * FIXED_BATCHES
                                  + RANDOM_BATCHES + RELOAD_CYCLES + GAP_CYCLES
                                  + LATENCY + 1 + TAIL_CYCLES + MARGIN_CYCLES;

    localparam int SPLIT_NONE   = 0;
    localparam int SPLIT_ALL    = 1;
    localparam int SPLIT_RANDOM = 2;

    logic       clock;
    logic       reset;
    logic       rhs_load;
    rhs_vec_t   rhs_data;
    logic       in_valid;
    lhs_batch_t in_batch;
    logic       out_valid;
    seg_out_t   result;

    // testbench copy of the stored vector
    rhs_vec_t    model_rhs;
    logic [31:0] lfsr_state;
    int          cyc = 0;
    int          errors = 0;
    int          checks = 0;
    // name of the test whose stimulus is on the inputs
    string       phase = "reset_quiet";

    // expected results in send order, with the cycle each is due
    seg_out_t expected_q[$];
    int       due_q[$];
    string    name_q[$];

    `include "spmv_model.svh"

    spmv_lane dut0 (
        .clock      (clock),
        .reset      (reset),
        .rhs_load   (rhs_load),
        .rhs_data   (rhs_data),
        .in_valid   (in_valid),
        .in_batch   (in_batch),
        .out_valid  (out_valid),
        .result     (result)
    );

    initial begin
        clock = 1'b0;
    end

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    always @(posedge clock) begin
        cyc <= cyc + 1;
    end

    // ------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------
    task automatic take_bits(input int nbits, output logic [31:0] bits);
        bits = '0;
        for (int b = 0; b < nbits; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    task automatic random_vector(output rhs_vec_t vec);
        logic [31:0] r;

        vec = '0;
        for (int i = 0; i < `SPMV_N; i++) begin
            take_bits(`SPMV_W, r);
            vec[i] = r[`SPMV_W-1:0];
        end
    endtask

    task automatic random_batch(input int split_mode, output lhs_batch_t batch);
        logic [31:0] r;

        batch = '0;
        for (int i = 0; i < `SPMV_N; i++) begin
            take_bits(`SPMV_W, r);
            batch[i].value = r[`SPMV_W-1:0];
            take_bits(`SPMV_LG_N, r);
            batch[i].col = r[`SPMV_LG_N-1:0];
            case (split_mode)
                SPLIT_NONE: batch[i].split = 1'b0;
                SPLIT_ALL:  batch[i].split = 1'b1;
                default: begin
                    take_bits(1, r);
                    batch[i].split = r[0];
                end
            endcase
        end
    endtask

    // one clock of stimulus, the DUT samples it at the next edge
    task automatic drive_cycle(
        input string      name,
        input logic       valid,
        input lhs_batch_t batch,
        input logic       load,
        input rhs_vec_t   vec
    );
        @(posedge clock);
        in_valid <= valid;
        in_batch <= batch;
        rhs_load <= load;
        rhs_data <= vec;
        phase    <= name;
        // a batch on the load edge still sees the old vector
        if (valid) begin
            expected_q.push_back(expected_result(batch, model_rhs));
            due_q.push_back(cyc + 1 + LATENCY);
            name_q.push_back(name);
        end
        if (load) begin
            model_rhs = vec;
        end
    endtask

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    initial begin
        lhs_batch_t  batch;
        rhs_vec_t    vec;
        logic [31:0] r;
        logic        valid;
        logic        load;

        lfsr_state = 32'h6e5;
        model_rhs  = '0;
        reset    <= 1'b1;
        rhs_load <= 1'b0;
        rhs_data <= '0;
        in_valid <= 1'b0;
        in_batch <= '0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;

        repeat (QUIET_CYCLES) drive_cycle("reset_quiet", 1'b0, '0, 1'b0, '0);

        random_vector(vec);
        drive_cycle("all_splits", 1'b0, '0, 1'b1, vec);
        for (int k = 0; k < FIXED_BATCHES; k++) begin
            random_batch(SPLIT_ALL, batch);
            drive_cycle("all_splits", 1'b1, batch, 1'b0, '0);
        end

        for (int k = 0; k < FIXED_BATCHES; k++) begin
            random_batch(SPLIT_NONE, batch);
            drive_cycle("no_splits", 1'b1, batch, 1'b0, '0);
        end

        for (int k = 0; k < RANDOM_BATCHES; k++) begin
            random_batch(SPLIT_RANDOM, batch);
            drive_cycle("random_segments", 1'b1, batch, 1'b0, '0);
        end

        // first reload cycle always lands on a batch edge
        random_batch(SPLIT_RANDOM, batch);
        random_vector(vec);
        drive_cycle("vector_reload", 1'b1, batch, 1'b1, vec);
        for (int k = 1; k < RELOAD_CYCLES; k++) begin
            take_bits(2, r);
            valid = (r[1:0] != 2'd0);
            take_bits(3, r);
            load = (r[2:0] == 3'd0);
            random_batch(SPLIT_RANDOM, batch);
            random_vector(vec);
            drive_cycle("vector_reload", valid, batch, load, vec);
        end

        for (int k = 0; k < GAP_CYCLES; k++) begin
            take_bits(1, r);
            valid = r[0];
            random_batch(SPLIT_RANDOM, batch);
            drive_cycle("gaps", valid, batch, 1'b0, '0);
        end

        while (due_q.size() > 0) begin
            drive_cycle("drain", 1'b0, '0, 1'b0, '0);
        end
        repeat (TAIL_CYCLES) drive_cycle("tail", 1'b0, '0, 1'b0, '0);

        @(negedge clock);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // ------------------------------------------------------------
    // result checker
    // ------------------------------------------------------------
    always @(posedge clock) begin
        seg_out_t exp;
        string    name;
        int       due;

        if (cyc > 0) begin
            if (due_q.size() > 0 && due_q[0] == cyc) begin
                exp  = expected_q.pop_front();
                name = name_q.pop_front();
                due  = due_q.pop_front();
                checks++;
                if (out_valid !== 1'b1) begin
                    $display("error %s: out_valid expected 1 actual %b at cycle %0d",
                             name, out_valid, due);
                    errors++;
                end else begin
                    for (int i = 0; i < `SPMV_N; i++) begin
                        if (result.slot[i] !== exp.slot[i]) begin
                            $display("error %s: slot %0d expected %h actual %h",
                                     name, i, exp.slot[i], result.slot[i]);
                            errors++;
                        end
                    end
                    if (result.halo !== exp.halo) begin
                        $display("error %s: halo expected %h actual %h",
                                 name, exp.halo, result.halo);
                        errors++;
                    end
                    if (result.count !== exp.count) begin
                        $display("error %s: count expected %0d actual %0d",
                                 name, exp.count, result.count);
                        errors++;
                    end
                end
            end else if (out_valid !== 1'b0) begin
                $display("error %s: out_valid expected 0 actual %b at cycle %0d",
                         phase, out_valid, cyc);
                errors++;
            end
        end
    end

    // ------------------------------------------------------------
    // watchdog
    // ------------------------------------------------------------
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clock);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+design
+incdir+dv
design/spmv_pkg.sv
design/operand_gather.sv
design/segmented_scan.sv
design/segment_collect.sv
design/spmv_lane.sv
dv/spmv_lane_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the spmv lane testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    --top-module spmv_lane_tb -f sources.f -o spmv_lane_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/spmv_lane_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TB PASSED"; then
    exit 0
fi
echo "pass message not found"
exit 1
